// File: tb.f
+incdir+.
mem_layout_pkg.sv
mem_port_pkg.sv
bram_bank.sv
bram_array.sv
mem_addr_map.sv
mem_write_port.sv
mem_read_port.sv
main_mem.sv
main_mem_tb.sv

// File: main_mem_tb.sv
`include "main_mem_params.svh"

module main_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HS_LIMIT  = 16;   // edges allowed per handshake phase
  localparam int N_COL_RD  = 200;
  localparam int N_COL_WR  = 40;
  localparam int N_CELLS   = `BEATS_SALT + `BEATS_SEED_SE + `BEATS_PKH + `BEATS_K;
  localparam int N_CONC_RD = 24;
  localparam int N_B_CHECK = 32;
  localparam int N_NEXT    = 300;
  localparam int ROW_ELEMS = `LANES * `B_WORDS;   // elements in one B row
  localparam longint TOTAL_BEATS = 2 * `BEATS_B + N_COL_RD + 5 * N_COL_WR + 2 * N_CELLS +
                                   N_CONC_RD + N_B_CHECK + N_NEXT + 8;
  localparam longint WATCHDOG_NS = TOTAL_BEATS * 12 * 100 + 20000;

  logic                        clk;
  logic                        i_arst_n;
  logic                        i_wr_req;
  mem_layout_pkg::mem_op_e     i_wr_op;
  mem_layout_pkg::beat_index_t i_wr_index;
  mem_port_pkg::beat_t         i_wr_data;
  logic                        o_wr_ack;
  mem_layout_pkg::beat_index_t o_wr_index_next;
  logic                        o_wr_last;
  logic                        i_rd_req;
  mem_layout_pkg::mem_op_e     i_rd_op;
  mem_layout_pkg::beat_index_t i_rd_index;
  logic                        o_rd_ack;
  mem_port_pkg::beat_t         o_rd_data;
  mem_layout_pkg::beat_index_t o_rd_index_next;
  logic                        o_rd_last;

  logic [`ELEM_BITS-1:0] b_model [int];      // one entry per B element
  logic [`WORD_BITS-1:0] cell_model [int];   // one entry per cell word
  string                 test_name;

  main_mem DUT (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_wr_req        (i_wr_req),
    .i_wr_op         (i_wr_op),
    .i_wr_index      (i_wr_index),
    .i_wr_data       (i_wr_data),
    .o_wr_ack        (o_wr_ack),
    .o_wr_index_next (o_wr_index_next),
    .o_wr_last       (o_wr_last),
    .i_rd_req        (i_rd_req),
    .i_rd_op         (i_rd_op),
    .i_rd_index      (i_rd_index),
    .o_rd_ack        (o_rd_ack),
    .o_rd_data       (o_rd_data),
    .o_rd_index_next (o_rd_index_next),
    .o_rd_last       (o_rd_last)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests finished");
  end

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic int beat_count(input mem_layout_pkg::mem_op_e op);
    case (op)
      mem_layout_pkg::SALT:    return `BEATS_SALT;
      mem_layout_pkg::SEED_SE: return `BEATS_SEED_SE;
      mem_layout_pkg::PKH:     return `BEATS_PKH;
      mem_layout_pkg::K:       return `BEATS_K;
      default:                 return `BEATS_B;
    endcase
  endfunction

  function automatic int final_index(input mem_layout_pkg::mem_op_e op);
    if (op == mem_layout_pkg::B_ROW) begin
      return (`MEM_BANKS - 1) * `MEM_WORDS + `B_WORDS - 1;   // row 7, word 335
    end else begin
      return beat_count(op) - 1;
    end
  endfunction

  function automatic int next_index(input mem_layout_pkg::mem_op_e op, input int idx);
    if (op == mem_layout_pkg::B_ROW && idx % `MEM_WORDS == `B_WORDS - 1) begin
      return ((idx / `MEM_WORDS + 1) * `MEM_WORDS) % (1 << `IDX_BITS);
    end else begin
      return (idx + 1) % (1 << `IDX_BITS);
    end
  endfunction

  function automatic int random_index(input mem_layout_pkg::mem_op_e op);
    int r;
    int w;
    if (op == mem_layout_pkg::B_ROW) begin
      r = $urandom_range(`MEM_BANKS - 1);
      w = ($urandom_range(3) == 0) ? `B_WORDS - 1 : $urandom_range(`B_WORDS - 1);
      return r * `MEM_WORDS + w;
    end else begin
      return ($urandom_range(7) == 0) ? final_index(op) : $urandom_range(beat_count(op) - 1);
    end
  endfunction

  function automatic mem_layout_pkg::mem_op_e cell_op(input int n);
    return mem_layout_pkg::mem_op_e'(int'(mem_layout_pkg::SALT) + n);
  endfunction

  // B row and column of lane j of a beat
  function automatic int lane_row(input mem_layout_pkg::mem_op_e op, input int idx, input int j);
    return (op == mem_layout_pkg::B_ROW) ? idx / `MEM_WORDS : `LANES * (idx % 2) + j;
  endfunction

  function automatic int lane_col(input mem_layout_pkg::mem_op_e op, input int idx, input int j);
    return (op == mem_layout_pkg::B_ROW) ? `LANES * (idx % `MEM_WORDS) + j : idx / 2;
  endfunction

  function automatic int elem_key(input mem_layout_pkg::mem_op_e op, input int idx, input int j);
    return lane_row(op, idx, j) * ROW_ELEMS + lane_col(op, idx, j);
  endfunction

  function automatic bit is_b_op(input mem_layout_pkg::mem_op_e op);
    return (op == mem_layout_pkg::B_ROW) || (op == mem_layout_pkg::B_COL);
  endfunction

  task automatic record_write(input mem_layout_pkg::mem_op_e op, input int idx,
                              input logic [63:0] data);
    if (is_b_op(op)) begin
      for (int j = 0; j < `LANES; j++) begin
        b_model[elem_key(op, idx, j)] = data[j*`ELEM_BITS +: `ELEM_BITS];
      end
    end else begin
      cell_model[int'(op) * 64 + idx] = data;
    end
  endtask

  function automatic logic [63:0] expected_beat(input mem_layout_pkg::mem_op_e op, input int idx);
    logic [63:0] beat;
    beat = 'x;   // unwritten elements stay unknown
    if (is_b_op(op)) begin
      for (int j = 0; j < `LANES; j++) begin
        if (b_model.exists(elem_key(op, idx, j))) begin
          beat[j*`ELEM_BITS +: `ELEM_BITS] = b_model[elem_key(op, idx, j)];
        end
      end
    end else if (cell_model.exists(int'(op) * 64 + idx)) begin
      beat = cell_model[int'(op) * 64 + idx];
    end
    return beat;
  endfunction

  ////////////////////////////////////////////////////////////
  // client handshakes
  ////////////////////////////////////////////////////////////

  task automatic write_beat(input mem_layout_pkg::mem_op_e op, input int idx,
                            input logic [63:0] data);
    int waited;
    i_wr_op    = op;
    i_wr_index = mem_layout_pkg::beat_index_t'(idx);
    i_wr_data  = data;
    i_wr_req   = 1'b1;
    waited     = 0;
    while (o_wr_ack !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > HS_LIMIT) begin
        abort_run("write ack never rose after the request");
      end
    end
    check_value("wr ack rise delay", 0, waited - 1);   // commits on the sampling edge
    record_write(op, idx, data);
    i_wr_req = 1'b0;
    waited   = 0;
    while (o_wr_ack !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > HS_LIMIT) begin
        abort_run("write ack stayed high after the request dropped");
      end
    end
    check_value("wr ack fall delay", 0, waited - 1);
  endtask

  task automatic read_beat(input mem_layout_pkg::mem_op_e op, input int idx,
                           output logic [63:0] data);
    int waited;
    i_rd_op    = op;
    i_rd_index = mem_layout_pkg::beat_index_t'(idx);
    i_rd_req   = 1'b1;
    waited     = 0;
    while (o_rd_ack !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > HS_LIMIT) begin
        abort_run("read ack never rose after the request");
      end
    end
    check_value("rd ack rise delay", 3, waited - 1);   // three edges after the sample
    data     = o_rd_data;
    i_rd_req = 1'b0;
    waited   = 0;
    while (o_rd_ack !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > HS_LIMIT) begin
        abort_run("read ack stayed high after the request dropped");
      end
    end
    check_value("rd ack fall delay", 0, waited - 1);
  endtask

  task automatic check_read(input mem_layout_pkg::mem_op_e op, input int idx);
    logic [63:0] data;
    read_beat(op, idx, data);
    check_value($sformatf("%s index %0d", op.name(), idx), expected_beat(op, idx), data);
  endtask

  task automatic check_next(input mem_layout_pkg::mem_op_e wop, input int widx,
                            input mem_layout_pkg::mem_op_e rop, input int ridx);
    i_wr_op    = wop;
    i_wr_index = mem_layout_pkg::beat_index_t'(widx);
    i_rd_op    = rop;
    i_rd_index = mem_layout_pkg::beat_index_t'(ridx);
    @(negedge clk);
    check_value($sformatf("wr next %s %0d", wop.name(), widx), next_index(wop, widx),
                o_wr_index_next);
    check_value($sformatf("wr last %s %0d", wop.name(), widx), widx == final_index(wop),
                o_wr_last);
    check_value($sformatf("rd next %s %0d", rop.name(), ridx), next_index(rop, ridx),
                o_rd_index_next);
    check_value($sformatf("rd last %s %0d", rop.name(), ridx), ridx == final_index(rop),
                o_rd_last);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int col_ks[$];
    int k;
    mem_layout_pkg::mem_op_e op;
    i_arst_n   = 1'b0;
    i_wr_req   = 1'b0;
    i_wr_op    = mem_layout_pkg::B_ROW;
    i_wr_index = '0;
    i_wr_data  = '0;
    i_rd_req   = 1'b0;
    i_rd_op    = mem_layout_pkg::B_ROW;
    i_rd_index = '0;
    void'($urandom(32'hd22b_7138));
    test_name = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);
    check_value("wr ack", 0, o_wr_ack);
    check_value("rd ack", 0, o_rd_ack);
    check_value("rd data", 0, o_rd_data);

    test_name = "b_row_pass";
    for (int i = 0; i <= final_index(mem_layout_pkg::B_ROW);
         i = next_index(mem_layout_pkg::B_ROW, i)) begin
      write_beat(mem_layout_pkg::B_ROW, i, {$urandom, $urandom});
    end
    for (int i = 0; i <= final_index(mem_layout_pkg::B_ROW);
         i = next_index(mem_layout_pkg::B_ROW, i)) begin
      check_read(mem_layout_pkg::B_ROW, i);
    end

    test_name = "b_col_read";
    repeat (N_COL_RD) check_read(mem_layout_pkg::B_COL, random_index(mem_layout_pkg::B_COL));

    test_name = "b_col_write";
    repeat (N_COL_WR) begin
      k = random_index(mem_layout_pkg::B_COL);
      col_ks.push_back(k);
      write_beat(mem_layout_pkg::B_COL, k, {$urandom, $urandom});
    end
    foreach (col_ks[n]) begin
      for (int j = 0; j < `LANES; j++) begin   // rows 4h+j, word c/4
        check_read(mem_layout_pkg::B_ROW,
                   lane_row(mem_layout_pkg::B_COL, col_ks[n], j) * `MEM_WORDS + col_ks[n] / 8);
      end
    end

    test_name = "cells";
    fork
      begin
        for (int n = 0; n < 4; n++) begin
          for (int i = 0; i < beat_count(cell_op(n)); i++) begin
            write_beat(cell_op(n), i, {$urandom, $urandom});
          end
        end
      end
      begin
        repeat (N_CONC_RD) check_read(mem_layout_pkg::B_ROW, random_index(mem_layout_pkg::B_ROW));
      end
    join
    for (int n = 0; n < 4; n++) begin
      for (int i = 0; i < beat_count(cell_op(n)); i++) begin
        check_read(cell_op(n), i);
      end
    end
    repeat (N_B_CHECK) check_read(mem_layout_pkg::B_ROW, random_index(mem_layout_pkg::B_ROW));

    test_name = "next_index";
    check_next(mem_layout_pkg::B_ROW, final_index(mem_layout_pkg::B_ROW),
               mem_layout_pkg::B_ROW, `B_WORDS - 1);
    repeat (N_NEXT) begin
      op = mem_layout_pkg::mem_op_e'($urandom_range(5));
      k  = random_index(op);
      check_next(op, k, mem_layout_pkg::mem_op_e'(5 - int'(op)),
                 random_index(mem_layout_pkg::mem_op_e'(5 - int'(op))));
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// File: main_mem.sv
`include "main_mem_params.svh"

module main_mem (
  input  logic                        clk,
  input  logic                        i_arst_n,
  // write client
  input  logic                        i_wr_req,
  input  mem_layout_pkg::mem_op_e     i_wr_op,
  input  mem_layout_pkg::beat_index_t i_wr_index,
  input  mem_port_pkg::beat_t         i_wr_data,
  output logic                        o_wr_ack,
  output mem_layout_pkg::beat_index_t o_wr_index_next,
  output logic                        o_wr_last,
  // read client
  input  logic                        i_rd_req,
  input  mem_layout_pkg::mem_op_e     i_rd_op,
  input  mem_layout_pkg::beat_index_t i_rd_index,
  output logic                        o_rd_ack,
  output mem_port_pkg::beat_t         o_rd_data,
  output mem_layout_pkg::beat_index_t o_rd_index_next,
  output logic                        o_rd_last
);

  mem_layout_pkg::bank_addr_t             wr_addr;
  mem_layout_pkg::bank_sel_t              wr_banks;
  mem_layout_pkg::lane_sel_t              wr_lanes;
  mem_layout_pkg::word_t [`MEM_BANKS-1:0] wr_words;
  mem_layout_pkg::bank_addr_t             rd_addr;
  mem_layout_pkg::bank_sel_t              rd_banks;
  mem_layout_pkg::lane_sel_t              rd_lanes;
  mem_layout_pkg::word_t [`MEM_BANKS-1:0] rd_words;

  // bank port A
  mem_write_port u_wr_port (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_req        (i_wr_req),
    .i_op         (i_wr_op),
    .i_index      (i_wr_index),
    .i_data       (i_wr_data),
    .o_ack        (o_wr_ack),
    .o_index_next (o_wr_index_next),
    .o_last       (o_wr_last),
    .o_bank_addr  (wr_addr),
    .o_banks      (wr_banks),
    .o_lanes      (wr_lanes),
    .o_words      (wr_words)
  );

  // bank port B
  mem_read_port u_rd_port (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_req        (i_rd_req),
    .i_op         (i_rd_op),
    .i_index      (i_rd_index),
    .o_ack        (o_rd_ack),
    .o_data       (o_rd_data),
    .o_index_next (o_rd_index_next),
    .o_last       (o_rd_last),
    .o_bank_addr  (rd_addr),
    .o_banks      (rd_banks),
    .o_lanes      (rd_lanes),
    .i_words      (rd_words)
  );

  bram_array u_banks (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_wr_banks (wr_banks),
    .i_wr_lanes (wr_lanes),
    .i_wr_addr  (wr_addr),
    .i_wr_words (wr_words),
    .i_rd_banks (rd_banks),
    .i_rd_lanes (rd_lanes),
    .i_rd_addr  (rd_addr),
    .o_rd_words (rd_words)
  );

endmodule

// File: mem_read_port.sv
`include "main_mem_params.svh"

module mem_read_port (
  input  logic                                    clk,
  input  logic                                    i_arst_n,
  input  logic                                    i_req,
  input  mem_layout_pkg::mem_op_e                 i_op,
  input  mem_layout_pkg::beat_index_t             i_index,
  output logic                                    o_ack,
  output mem_port_pkg::beat_t                     o_data,
  output mem_layout_pkg::beat_index_t             o_index_next,
  output logic                                    o_last,
  output mem_layout_pkg::bank_addr_t              o_bank_addr,
  output mem_layout_pkg::bank_sel_t               o_banks,
  output mem_layout_pkg::lane_sel_t               o_lanes,
  input  mem_layout_pkg::word_t [`MEM_BANKS-1:0]  i_words
);

  localparam int CNT_BITS = $clog2(`RD_LATENCY + 1);

  mem_port_pkg::hs_state_e     state;
  logic [CNT_BITS-1:0]         wait_cnt;
  mem_layout_pkg::mem_op_e     op_q;
  mem_layout_pkg::beat_index_t index_q;
  mem_layout_pkg::mem_op_e     map_op;
  mem_layout_pkg::beat_index_t map_index;
  mem_layout_pkg::bank_sel_t   map_banks;
  logic                        rd_issue;
  mem_layout_pkg::word_t       row_word;
  mem_port_pkg::beat_t         col_beat;
  mem_port_pkg::beat_t         merged;

  // live inputs while idle, held access otherwise
  assign map_op    = (state == mem_port_pkg::IDLE) ? i_op : op_q;
  assign map_index = (state == mem_port_pkg::IDLE) ? i_index : index_q;

  mem_addr_map u_map (
    .i_op         (map_op),
    .i_index      (map_index),
    .o_bank_addr  (o_bank_addr),
    .o_banks      (map_banks),
    .o_lanes      (o_lanes),
    .o_index_next (o_index_next),
    .o_last       (o_last)
  );

  always_ff @(posedge clk) begin
    if ((state == mem_port_pkg::IDLE) && i_req) begin
      op_q    <= i_op;
      index_q <= i_index;
    end
  end

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // banks see the read during the first WAIT_DATA cycle
  assign rd_issue = (state == mem_port_pkg::WAIT_DATA) && (wait_cnt == '0);
  assign o_banks  = map_banks & {`MEM_BANKS{rd_issue}};

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= mem_port_pkg::IDLE;
      wait_cnt <= '0;
      o_data   <= '0;
    end else begin
      case (state)
        mem_port_pkg::IDLE: begin
          if (i_req) begin
            state    <= mem_port_pkg::WAIT_DATA;
            wait_cnt <= '0;
          end
        end
        mem_port_pkg::WAIT_DATA: begin
          if (wait_cnt == CNT_BITS'(`RD_LATENCY)) begin
            o_data <= merged;   // masked words valid this cycle only
            state  <= mem_port_pkg::ACK;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        mem_port_pkg::ACK: begin
          if (!i_req) begin
            state <= mem_port_pkg::IDLE;
          end
        end
        default: begin
          state <= mem_port_pkg::IDLE;
        end
      endcase
    end
  end

  assign o_ack = (state == mem_port_pkg::ACK);

  ////////////////////////////////////////////////////////////
  // merge
  ////////////////////////////////////////////////////////////

  always_comb begin
    row_word = '0;
    for (int b = 0; b < `MEM_BANKS; b++) begin
      row_word |= i_words[b];
    end
    // lane j from bank 4h+j, any of its lanes
    for (int j = 0; j < `LANES; j++) begin
      col_beat[j] = '0;
      for (int l = 0; l < `LANES; l++) begin
        col_beat[j] |= i_words[index_q[0] * `LANES + j][l*`ELEM_BITS +: `ELEM_BITS];
      end
    end
    merged = (op_q == mem_layout_pkg::B_COL) ? col_beat : row_word;
  end

endmodule

// File: mem_write_port.sv
`include "main_mem_params.svh"

module mem_write_port (
  input  logic                                    clk,
  input  logic                                    i_arst_n,
  input  logic                                    i_req,
  input  mem_layout_pkg::mem_op_e                 i_op,
  input  mem_layout_pkg::beat_index_t             i_index,
  input  mem_port_pkg::beat_t                     i_data,
  output logic                                    o_ack,
  output mem_layout_pkg::beat_index_t             o_index_next,
  output logic                                    o_last,
  output mem_layout_pkg::bank_addr_t              o_bank_addr,
  output mem_layout_pkg::bank_sel_t               o_banks,
  output mem_layout_pkg::lane_sel_t               o_lanes,
  output mem_layout_pkg::word_t [`MEM_BANKS-1:0]  o_words
);

  mem_port_pkg::hs_state_e   state;
  mem_layout_pkg::bank_sel_t map_banks;
  logic                      wr_fire;

  mem_addr_map u_map (
    .i_op         (i_op),
    .i_index      (i_index),
    .o_bank_addr  (o_bank_addr),
    .o_banks      (map_banks),
    .o_lanes      (o_lanes),
    .o_index_next (o_index_next),
    .o_last       (o_last)
  );

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // write commits on the edge that first sees the request
  assign wr_fire = (state == mem_port_pkg::IDLE) && i_req;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= mem_port_pkg::IDLE;
    end else begin
      case (state)
        mem_port_pkg::IDLE: begin
          if (i_req) begin
            state <= mem_port_pkg::ACK;
          end
        end
        mem_port_pkg::ACK: begin
          if (!i_req) begin
            state <= mem_port_pkg::IDLE;   // ack drops here
          end
        end
        default: begin
          state <= mem_port_pkg::IDLE;
        end
      endcase
    end
  end

  assign o_ack   = (state == mem_port_pkg::ACK);
  assign o_banks = map_banks & {`MEM_BANKS{wr_fire}};

  ////////////////////////////////////////////////////////////
  // data placement
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < `MEM_BANKS; b++) begin
      if (i_op == mem_layout_pkg::B_COL) begin
        o_words[b] = {`LANES{i_data[b % `LANES]}};   // element j into bank 4h+j
      end else begin
        o_words[b] = i_data;   // broadcast
      end
    end
  end

endmodule

// File: mem_addr_map.sv
`include "main_mem_params.svh"

module mem_addr_map (
  input  mem_layout_pkg::mem_op_e     i_op,
  input  mem_layout_pkg::beat_index_t i_index,
  output mem_layout_pkg::bank_addr_t  o_bank_addr,
  output mem_layout_pkg::bank_sel_t   o_banks,
  output mem_layout_pkg::lane_sel_t   o_lanes,
  output mem_layout_pkg::beat_index_t o_index_next,
  output logic                        o_last
);

  localparam int ROW_BITS = $clog2(`MEM_WORDS);   // word field of a B row index

  // row 7, word 335
  localparam mem_layout_pkg::beat_index_t LAST_B_ROW =
    mem_layout_pkg::beat_index_t'((`MEM_BANKS - 1) * `MEM_WORDS + `B_WORDS - 1);

  mem_layout_pkg::bank_addr_t  cell_word;
  mem_layout_pkg::bank_sel_t   cell_bank;
  mem_layout_pkg::beat_index_t last_index;
  logic                        row_wrap;

  assign cell_word = i_index[3 +: ROW_BITS];   // k / 8
  assign cell_bank = mem_layout_pkg::bank_sel_t'(1) << i_index[2:0];

  ////////////////////////////////////////////////////////////
  // storage rule
  ////////////////////////////////////////////////////////////

  always_comb begin
    o_bank_addr = '0;
    o_banks     = '0;
    o_lanes     = '1;
    last_index  = '0;
    case (i_op)
      mem_layout_pkg::B_ROW: begin
        o_bank_addr = `OFF_B + i_index[ROW_BITS-1:0];
        o_banks     = mem_layout_pkg::bank_sel_t'(1) << i_index[ROW_BITS +: 3];
        last_index  = LAST_B_ROW;
      end
      mem_layout_pkg::B_COL: begin
        // column c = k/2, half h = k mod 2
        o_bank_addr = `OFF_B + i_index[3 +: ROW_BITS];
        o_banks     = {{`LANES{i_index[0]}}, {`LANES{~i_index[0]}}};
        o_lanes     = mem_layout_pkg::lane_sel_t'(1) << i_index[2:1];
        last_index  = mem_layout_pkg::beat_index_t'(`BEATS_B - 1);
      end
      mem_layout_pkg::SALT: begin
        o_bank_addr = `OFF_SALT + cell_word;
        o_banks     = cell_bank;
        last_index  = mem_layout_pkg::beat_index_t'(`BEATS_SALT - 1);
      end
      mem_layout_pkg::SEED_SE: begin
        o_bank_addr = `OFF_SEED_SE + cell_word;
        o_banks     = cell_bank;
        last_index  = mem_layout_pkg::beat_index_t'(`BEATS_SEED_SE - 1);
      end
      mem_layout_pkg::PKH: begin
        o_bank_addr = `OFF_PKH + cell_word;
        o_banks     = cell_bank;
        last_index  = mem_layout_pkg::beat_index_t'(`BEATS_PKH - 1);
      end
      mem_layout_pkg::K: begin
        o_bank_addr = `OFF_K + cell_word;
        o_banks     = cell_bank;
        last_index  = mem_layout_pkg::beat_index_t'(`BEATS_K - 1);
      end
      default: begin
        o_lanes = '0;   // no access
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next index and last beat
  ////////////////////////////////////////////////////////////

  assign row_wrap = (i_op == mem_layout_pkg::B_ROW) &&
                    (i_index[ROW_BITS-1:0] == ROW_BITS'(`B_WORDS - 1));

  always_comb begin
    if (row_wrap) begin
      o_index_next = {i_index[`IDX_BITS-1:ROW_BITS] + 1'b1, {ROW_BITS{1'b0}}};
    end else begin
      o_index_next = i_index + 1'b1;
    end
  end

  assign o_last = (i_index == last_index);

endmodule

// File: bram_array.sv
`include "main_mem_params.svh"

module bram_array (
  input  logic                                    clk,
  input  logic                                    i_arst_n,
  input  mem_layout_pkg::bank_sel_t               i_wr_banks,
  input  mem_layout_pkg::lane_sel_t               i_wr_lanes,
  input  mem_layout_pkg::bank_addr_t              i_wr_addr,
  input  mem_layout_pkg::word_t [`MEM_BANKS-1:0]  i_wr_words,
  input  mem_layout_pkg::bank_sel_t               i_rd_banks,
  input  mem_layout_pkg::lane_sel_t               i_rd_lanes,
  input  mem_layout_pkg::bank_addr_t              i_rd_addr,
  output mem_layout_pkg::word_t [`MEM_BANKS-1:0]  o_rd_words
);

  mem_layout_pkg::bank_sel_t banks_d1;
  mem_layout_pkg::bank_sel_t banks_d2;
  mem_layout_pkg::lane_sel_t lanes_d1;
  mem_layout_pkg::lane_sel_t lanes_d2;
  mem_layout_pkg::word_t [`MEM_BANKS-1:0] raw_words;

  // enables follow the data through both bank registers
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      banks_d1 <= '0;
      banks_d2 <= '0;
      lanes_d1 <= '0;
      lanes_d2 <= '0;
    end else begin
      banks_d1 <= i_rd_banks;
      banks_d2 <= banks_d1;
      lanes_d1 <= i_rd_lanes;
      lanes_d2 <= lanes_d1;
    end
  end

  for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank
    bram_bank u_bank (
      .clk        (clk),
      .i_wr_en    (i_wr_banks[b]),
      .i_wr_lanes (i_wr_lanes),
      .i_wr_addr  (i_wr_addr),
      .i_wr_word  (i_wr_words[b]),
      .i_rd_en    (i_rd_banks[b]),
      .i_rd_addr  (i_rd_addr),
      .o_rd_word  (raw_words[b])
    );

    // unselected lanes read as zero so the merge can OR
    for (genvar l = 0; l < `LANES; l++) begin : g_lane
      assign o_rd_words[b][l*`ELEM_BITS +: `ELEM_BITS] =
        raw_words[b][l*`ELEM_BITS +: `ELEM_BITS] & {`ELEM_BITS{banks_d2[b] & lanes_d2[l]}};
    end
  end

endmodule

// File: bram_bank.sv
`include "main_mem_params.svh"

module bram_bank (
  input  logic                       clk,
  input  logic                       i_wr_en,
  input  mem_layout_pkg::lane_sel_t  i_wr_lanes,
  input  mem_layout_pkg::bank_addr_t i_wr_addr,
  input  mem_layout_pkg::word_t      i_wr_word,
  input  logic                       i_rd_en,
  input  mem_layout_pkg::bank_addr_t i_rd_addr,
  output mem_layout_pkg::word_t      o_rd_word
);

  mem_layout_pkg::word_t mem [`MEM_WORDS];
  mem_layout_pkg::word_t rd_d1;
  mem_layout_pkg::word_t rd_d2;

  // port A, lane-masked write
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int l = 0; l < `LANES; l++) begin
        if (i_wr_lanes[l]) begin
          mem[i_wr_addr][l*`ELEM_BITS +: `ELEM_BITS] <= i_wr_word[l*`ELEM_BITS +: `ELEM_BITS];
        end
      end
    end
  end

  // port B
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_d1 <= mem[i_rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    rd_d2 <= rd_d1;   // output register, always loads
  end

  assign o_rd_word = rd_d2;

endmodule

// File: mem_port_pkg.sv
`include "main_mem_params.svh"

package mem_port_pkg;

  // four-phase client handshake
  typedef enum logic [1:0] {
    IDLE,
    WAIT_DATA,  // read only, bank latency
    ACK
  } hs_state_e;

  typedef logic [`LANES-1:0][`ELEM_BITS-1:0] beat_t;   // lane j in element j

endpackage

// File: mem_layout_pkg.sv
`include "main_mem_params.svh"

package mem_layout_pkg;

  // access opcodes
  typedef enum logic [2:0] {
    B_ROW,    // four elements of one B row
    B_COL,    // four elements of one B column
    SALT,
    SEED_SE,
    PKH,
    K
  } mem_op_e;

  typedef logic [$clog2(`MEM_WORDS)-1:0] bank_addr_t;

  typedef logic [`MEM_BANKS-1:0] bank_sel_t;   // one bit per bank

  typedef logic [`LANES-1:0] lane_sel_t;       // one bit per 16-bit lane

  typedef logic [`IDX_BITS-1:0] beat_index_t;

  typedef logic [`WORD_BITS-1:0] word_t;

endpackage

// File: main_mem_params.svh
`ifndef MAIN_MEM_PARAMS_SVH
`define MAIN_MEM_PARAMS_SVH

////////////////////////////////////////////////////////////
// bank geometry
////////////////////////////////////////////////////////////

`define MEM_BANKS   8
`define MEM_WORDS   512     // words per bank
`define WORD_BITS   64
`define ELEM_BITS   16      // matrix element
`define LANES       4       // elements per word
`define B_WORDS     336     // words of one B row in a bank

////////////////////////////////////////////////////////////
// region word offsets
////////////////////////////////////////////////////////////

`define OFF_B       9'd0
`define OFF_SALT    9'd427
`define OFF_SEED_SE 9'd428
`define OFF_PKH     9'd429
`define OFF_K       9'd431

// beats per full pass of each access mode
`define BEATS_B       2688
`define BEATS_SALT    8
`define BEATS_SEED_SE 8
`define BEATS_PKH     4
`define BEATS_K       4

`define RD_LATENCY  2       // bank read delay
`define IDX_BITS    14

`endif
